// ==== design/ooo_settings.svh ====
`ifndef OOO_SETTINGS_SVH
`define OOO_SETTINGS_SVH

// data path width, also the immediate width after extension
`define OOO_XLEN 32

// architectural register count, x0 included
`define OOO_NUM_REGS 32

// reorder buffer entries, power of two so the pointers wrap on their own
`define OOO_ROB_SIZE 8

// alu reservation station slots
`define OOO_RS_DEPTH 3

`endif

// ==== design/ooo_pkg.sv ====
`include "ooo_settings.svh"

package ooo_pkg;

  typedef logic [`OOO_XLEN-1:0] word_t;   // data value or extended immediate
  typedef logic [31:0] instr_t;            // raw rv32 instruction word

  typedef logic [$clog2(`OOO_NUM_REGS)-1:0] reg_addr_t;
  typedef logic [$clog2(`OOO_ROB_SIZE)-1:0] rob_ix_t;

  // instruction class out of decode
  typedef enum logic [1:0] {
    it_op,
    it_op_imm,
    it_lui,
    it_unsupported
  } itype_e;

  // alu function, lui rides on add with rs1 = x0
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and
  } alu_func_e;

endpackage

// ==== design/inst_decode.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module inst_decode (
  input  ooo_pkg::instr_t    i_inst,
  output ooo_pkg::itype_e    o_itype,
  output ooo_pkg::alu_func_e o_alu_func,
  output ooo_pkg::reg_addr_t o_rd,
  output ooo_pkg::reg_addr_t o_rs1,
  output ooo_pkg::reg_addr_t o_rs2,
  output ooo_pkg::word_t     o_imm,
  output logic               o_use_imm
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       alt;    // funct7[5], picks sub / sra

  assign opcode = i_inst[6:0];
  assign funct3 = i_inst[14:12];
  assign alt    = i_inst[30];

  // funct3 to alu function, sub only exists in the register form
  function automatic ooo_pkg::alu_func_e func_sel(input logic [2:0] f3, input logic alt_sub,
                                                  input logic alt_shift);
    case (f3)
      3'b000:  func_sel = alt_sub ? ooo_pkg::alu_sub : ooo_pkg::alu_add;
      3'b001:  func_sel = ooo_pkg::alu_sll;
      3'b010:  func_sel = ooo_pkg::alu_slt;
      3'b011:  func_sel = ooo_pkg::alu_sltu;
      3'b100:  func_sel = ooo_pkg::alu_xor;
      3'b101:  func_sel = alt_shift ? ooo_pkg::alu_sra : ooo_pkg::alu_srl;
      3'b110:  func_sel = ooo_pkg::alu_or;
      default: func_sel = ooo_pkg::alu_and;
    endcase
  endfunction

  always_comb begin
    o_itype    = ooo_pkg::it_unsupported;
    o_alu_func = ooo_pkg::alu_add;
    o_rd       = i_inst[11:7];
    o_rs1      = i_inst[19:15];
    o_rs2      = i_inst[24:20];
    o_imm      = {{20{i_inst[31]}}, i_inst[31:20]}; // i-type by default
    o_use_imm  = 1'b0;
    case (opcode)
      7'b0110011: begin
        o_itype    = ooo_pkg::it_op;
        o_alu_func = func_sel(funct3, alt, alt);
      end
      7'b0010011: begin
        o_itype    = ooo_pkg::it_op_imm;
        o_alu_func = func_sel(funct3, 1'b0, alt);
        o_use_imm  = 1'b1;
        if (funct3 == 3'b001 || funct3 == 3'b101) begin
          o_imm = {27'b0, i_inst[24:20]}; // shamt only
        end
      end
      7'b0110111: begin
        o_itype   = ooo_pkg::it_lui;
        o_rs1     = '0;                   // 0 + imm
        o_imm     = {i_inst[31:12], 12'b0};
        o_use_imm = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// ==== design/rename_regfile.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module rename_regfile (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  ooo_pkg::reg_addr_t i_rs1,
  input  ooo_pkg::reg_addr_t i_rs2,
  input  ooo_pkg::reg_addr_t i_rename_rd,
  input  logic               i_rename_en,
  input  ooo_pkg::rob_ix_t   i_rename_ix,
  input  logic               i_commit_valid,
  input  ooo_pkg::reg_addr_t i_commit_rd,
  input  ooo_pkg::rob_ix_t   i_commit_ix,
  input  ooo_pkg::word_t     i_commit_value,
  output ooo_pkg::word_t     o_val1,
  output ooo_pkg::word_t     o_val2,
  output logic               o_busy1,
  output logic               o_busy2,
  output ooo_pkg::rob_ix_t   o_tag1,
  output ooo_pkg::rob_ix_t   o_tag2
);

  ooo_pkg::word_t           regs [`OOO_NUM_REGS];
  ooo_pkg::rob_ix_t         tags [`OOO_NUM_REGS];  // rob entry that will write the reg
  logic [`OOO_NUM_REGS-1:0] busy;

  // x0 is never written or tagged, so it reads as an idle zero
  assign o_val1  = regs[i_rs1];
  assign o_val2  = regs[i_rs2];
  assign o_busy1 = busy[i_rs1];
  assign o_busy2 = busy[i_rs2];
  assign o_tag1  = tags[i_rs1];
  assign o_tag2  = tags[i_rs2];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      for (int r = 0; r < `OOO_NUM_REGS; r++) begin
        regs[r] <= '0;
        tags[r] <= '0;
      end
      busy <= '0;
    end else begin
      if (i_commit_valid && i_commit_rd != '0) begin
        regs[i_commit_rd] <= i_commit_value;
        // only the newest producer releases the register
        if (tags[i_commit_rd] == i_commit_ix) begin
          busy[i_commit_rd] <= 1'b0;
        end
      end
      // comes last so a rename in the same cycle overrides the release
      if (i_rename_en && i_rename_rd != '0) begin
        busy[i_rename_rd] <= 1'b1;
        tags[i_rename_rd] <= i_rename_ix;
      end
    end
  end

endmodule

// ==== design/alu_station.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module alu_station (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               i_issue,
  input  ooo_pkg::alu_func_e i_func,
  input  ooo_pkg::rob_ix_t   i_rob_ix,
  input  ooo_pkg::word_t     i_vi,
  input  ooo_pkg::word_t     i_vj,
  input  logic               i_ready_i,
  input  logic               i_ready_j,
  input  ooo_pkg::rob_ix_t   i_qi,
  input  ooo_pkg::rob_ix_t   i_qj,
  input  logic               i_cdb_valid,
  input  ooo_pkg::rob_ix_t   i_cdb_rob_ix,
  input  ooo_pkg::word_t     i_cdb_value,
  output logic               o_full,
  output logic               o_disp_valid,
  output ooo_pkg::alu_func_e o_disp_func,
  output ooo_pkg::word_t     o_disp_a,
  output ooo_pkg::word_t     o_disp_b,
  output ooo_pkg::rob_ix_t   o_disp_rob_ix
);

  localparam int DEPTH = `OOO_RS_DEPTH;
  localparam int SEL_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int AGE_W = $clog2(DEPTH + 1);

  logic [DEPTH-1:0]   busy;
  logic [DEPTH-1:0]   rdy_i;
  logic [DEPTH-1:0]   rdy_j;
  logic [AGE_W-1:0]   age [DEPTH];  // number of older entries, 0 is oldest
  ooo_pkg::alu_func_e func_q [DEPTH];
  ooo_pkg::rob_ix_t   rob_ix_q [DEPTH];
  ooo_pkg::rob_ix_t   qi_q [DEPTH];
  ooo_pkg::rob_ix_t   qj_q [DEPTH];
  ooo_pkg::word_t     vi_q [DEPTH];
  ooo_pkg::word_t     vj_q [DEPTH];

  logic [DEPTH-1:0] wake_i;
  logic [DEPTH-1:0] wake_j;
  logic             disp_hit;
  logic [SEL_W-1:0] disp_sel;
  logic [AGE_W-1:0] best_age;
  logic             free_hit;
  logic [SEL_W-1:0] free_sel;
  logic [AGE_W-1:0] used;

  always_comb begin
    disp_hit = 1'b0;
    disp_sel = '0;
    best_age = '1;
    free_hit = 1'b0;
    free_sel = '0;
    used     = '0;
    for (int e = 0; e < DEPTH; e++) begin
      // bus snoop for operands still waiting on a tag
      wake_i[e] = busy[e] && !rdy_i[e] && i_cdb_valid && qi_q[e] == i_cdb_rob_ix;
      wake_j[e] = busy[e] && !rdy_j[e] && i_cdb_valid && qj_q[e] == i_cdb_rob_ix;
      if (busy[e]) used = used + 1'b1;
      if (busy[e] && rdy_i[e] && rdy_j[e] && (!disp_hit || age[e] < best_age)) begin
        disp_hit = 1'b1;
        disp_sel = SEL_W'(e);
        best_age = age[e];
      end
      if (!busy[e] && !free_hit) begin  // lowest free slot
        free_hit = 1'b1;
        free_sel = SEL_W'(e);
      end
    end
  end

  assign o_full        = &busy;
  assign o_disp_valid  = disp_hit;
  assign o_disp_func   = func_q[disp_sel];
  assign o_disp_a      = vi_q[disp_sel];
  assign o_disp_b      = vj_q[disp_sel];
  assign o_disp_rob_ix = rob_ix_q[disp_sel];

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      busy  <= '0;
      rdy_i <= '0;
      rdy_j <= '0;
      for (int e = 0; e < DEPTH; e++) age[e] <= '0;
    end else begin
      for (int e = 0; e < DEPTH; e++) begin
        if (wake_i[e]) rdy_i[e] <= 1'b1;
        if (wake_j[e]) rdy_j[e] <= 1'b1;
        // younger entries move up when the dispatched one leaves
        if (disp_hit && busy[e] && age[e] > age[disp_sel]) age[e] <= age[e] - 1'b1;
      end
      if (disp_hit) busy[disp_sel] <= 1'b0;
      if (i_issue && free_hit) begin
        busy[free_sel]  <= 1'b1;
        rdy_i[free_sel] <= i_ready_i;
        rdy_j[free_sel] <= i_ready_j;
        age[free_sel]   <= used - AGE_W'(disp_hit);
      end
    end
  end

  // operand payload
  always_ff @(posedge clk_100mhz) begin
    for (int e = 0; e < DEPTH; e++) begin
      if (wake_i[e]) vi_q[e] <= i_cdb_value;
      if (wake_j[e]) vj_q[e] <= i_cdb_value;
    end
    if (i_issue && free_hit) begin
      func_q[free_sel]   <= i_func;
      rob_ix_q[free_sel] <= i_rob_ix;
      qi_q[free_sel]     <= i_qi;
      qj_q[free_sel]     <= i_qj;
      vi_q[free_sel]     <= i_vi;
      vj_q[free_sel]     <= i_vj;
    end
  end

endmodule

// ==== design/alu_unit.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module alu_unit (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               i_valid,
  input  ooo_pkg::alu_func_e i_func,
  input  ooo_pkg::word_t     i_a,
  input  ooo_pkg::word_t     i_b,
  input  ooo_pkg::rob_ix_t   i_rob_ix,
  output logic               o_cdb_valid,
  output ooo_pkg::rob_ix_t   o_cdb_rob_ix,
  output ooo_pkg::word_t     o_cdb_value
);

  localparam int SH_W = $clog2(`OOO_XLEN);

  ooo_pkg::word_t  result;
  logic [SH_W-1:0] shamt;

  assign shamt = i_b[SH_W-1:0];  // rv32 masks the shift amount

  always_comb begin
    case (i_func)
      ooo_pkg::alu_add:  result = i_a + i_b;
      ooo_pkg::alu_sub:  result = i_a - i_b;
      ooo_pkg::alu_sll:  result = i_a << shamt;
      ooo_pkg::alu_slt:  result = ooo_pkg::word_t'($signed(i_a) < $signed(i_b));
      ooo_pkg::alu_sltu: result = ooo_pkg::word_t'(i_a < i_b);
      ooo_pkg::alu_xor:  result = i_a ^ i_b;
      ooo_pkg::alu_srl:  result = i_a >> shamt;
      ooo_pkg::alu_sra:  result = ooo_pkg::word_t'($signed(i_a) >>> shamt);
      ooo_pkg::alu_or:   result = i_a | i_b;
      ooo_pkg::alu_and:  result = i_a & i_b;
      default:           result = '0;
    endcase
  end

  // this register is the result bus
  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) o_cdb_valid <= 1'b0;
    else o_cdb_valid <= i_valid;  // one cycle pulse per dispatch
  end

  always_ff @(posedge clk_100mhz) begin
    o_cdb_rob_ix <= i_rob_ix;
    o_cdb_value  <= result;
  end

endmodule

// ==== design/reorder_buffer.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module reorder_buffer (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               i_alloc,
  input  ooo_pkg::reg_addr_t i_alloc_rd,
  input  ooo_pkg::rob_ix_t   i_q1,
  input  ooo_pkg::rob_ix_t   i_q2,
  input  logic               i_cdb_valid,
  input  ooo_pkg::rob_ix_t   i_cdb_rob_ix,
  input  ooo_pkg::word_t     i_cdb_value,
  output ooo_pkg::rob_ix_t   o_tail_ix,
  output logic               o_full,
  output logic               o_q1_ready,
  output logic               o_q2_ready,
  output ooo_pkg::word_t     o_q1_value,
  output ooo_pkg::word_t     o_q2_value,
  output logic               o_commit_valid,
  output ooo_pkg::reg_addr_t o_commit_rd,
  output ooo_pkg::word_t     o_commit_value,
  output ooo_pkg::rob_ix_t   o_commit_ix
);

  localparam int SIZE  = `OOO_ROB_SIZE;
  localparam int CNT_W = $clog2(SIZE) + 1;

  ooo_pkg::reg_addr_t rd_q [SIZE];
  ooo_pkg::word_t     value_q [SIZE];
  logic [SIZE-1:0]    done;   // result written, waiting for commit

  ooo_pkg::rob_ix_t head;
  ooo_pkg::rob_ix_t tail;
  logic [CNT_W-1:0] count;

  logic hit1;
  logic hit2;

  assign o_tail_ix = tail;
  assign o_full    = count == CNT_W'(SIZE);

  // operand lookup, a result on the bus this cycle counts as ready
  assign hit1       = i_cdb_valid && i_cdb_rob_ix == i_q1;
  assign hit2       = i_cdb_valid && i_cdb_rob_ix == i_q2;
  assign o_q1_ready = done[i_q1] || hit1;
  assign o_q2_ready = done[i_q2] || hit2;
  assign o_q1_value = hit1 ? i_cdb_value : value_q[i_q1];
  assign o_q2_value = hit2 ? i_cdb_value : value_q[i_q2];

  // head commits as soon as it is done; done of a freed entry is stale
  assign o_commit_valid = count != '0 && done[head];
  assign o_commit_rd    = rd_q[head];
  assign o_commit_value = value_q[head];
  assign o_commit_ix    = head;

  always_ff @(posedge clk_100mhz) begin
    if (sys_rst) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      done  <= '0;
    end else begin
      if (i_alloc) begin
        done[tail] <= 1'b0;
        tail       <= tail + 1'b1;  // wraps at SIZE
      end
      if (i_cdb_valid) done[i_cdb_rob_ix] <= 1'b1;
      if (o_commit_valid) head <= head + 1'b1;
      count <= count + CNT_W'(i_alloc) - CNT_W'(o_commit_valid);
    end
  end

  always_ff @(posedge clk_100mhz) begin
    if (i_alloc) rd_q[tail] <= i_alloc_rd;
    if (i_cdb_valid) value_q[i_cdb_rob_ix] <= i_cdb_value;
  end

endmodule

// ==== design/ooo_core.sv ====
`timescale 1ns/1ns
`include "ooo_settings.svh"

module ooo_core (
  input  logic               clk_100mhz,
  input  logic               sys_rst,
  input  logic               i_inst_valid,
  input  ooo_pkg::instr_t    i_inst,
  output logic               o_inst_ready,
  output logic               o_commit_valid,
  output ooo_pkg::reg_addr_t o_commit_rd,
  output ooo_pkg::word_t     o_commit_value
);

  ooo_pkg::itype_e    itype;
  ooo_pkg::alu_func_e alu_func;
  ooo_pkg::reg_addr_t rd, rs1, rs2;
  ooo_pkg::word_t     imm;
  logic               use_imm;

  ooo_pkg::word_t   rf_val1, rf_val2;
  logic             rf_busy1, rf_busy2;
  ooo_pkg::rob_ix_t rf_tag1, rf_tag2;

  ooo_pkg::rob_ix_t rob_tail;
  logic             rob_full, rs_full;
  logic             q1_ready, q2_ready;
  ooo_pkg::word_t   q1_value, q2_value;
  ooo_pkg::rob_ix_t commit_ix;

  logic               disp_valid;
  ooo_pkg::alu_func_e disp_func;
  ooo_pkg::word_t     disp_a, disp_b;
  ooo_pkg::rob_ix_t   disp_rob_ix;

  logic             cdb_valid;
  ooo_pkg::rob_ix_t cdb_rob_ix;
  ooo_pkg::word_t   cdb_value;

  logic           accept, issue;
  ooo_pkg::word_t op_a, op_b;
  logic           rdy_a, rdy_b;

  assign o_inst_ready = !rob_full && !rs_full;
  assign accept       = i_inst_valid && o_inst_ready;
  assign issue        = accept && itype != ooo_pkg::it_unsupported; // others are dropped

  // operand source: reg file, rob lookup, or immediate
  always_comb begin
    op_a  = rf_busy1 ? q1_value : rf_val1;
    rdy_a = !rf_busy1 || q1_ready;
    if (use_imm) begin
      op_b  = imm;
      rdy_b = 1'b1;
    end else begin
      op_b  = rf_busy2 ? q2_value : rf_val2;
      rdy_b = !rf_busy2 || q2_ready;
    end
  end

  inst_decode inst_decode_i (
    .i_inst(i_inst), .o_itype(itype), .o_alu_func(alu_func), .o_rd(rd),
    .o_rs1(rs1), .o_rs2(rs2), .o_imm(imm), .o_use_imm(use_imm)
  );

  rename_regfile rename_regfile_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_rs1(rs1), .i_rs2(rs2),
    .i_rename_rd(rd), .i_rename_en(issue), .i_rename_ix(rob_tail),
    .i_commit_valid(o_commit_valid), .i_commit_rd(o_commit_rd),
    .i_commit_ix(commit_ix), .i_commit_value(o_commit_value),
    .o_val1(rf_val1), .o_val2(rf_val2), .o_busy1(rf_busy1), .o_busy2(rf_busy2),
    .o_tag1(rf_tag1), .o_tag2(rf_tag2)
  );

  reorder_buffer reorder_buffer_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_alloc(issue), .i_alloc_rd(rd),
    .i_q1(rf_tag1), .i_q2(rf_tag2), .i_cdb_valid(cdb_valid),
    .i_cdb_rob_ix(cdb_rob_ix), .i_cdb_value(cdb_value), .o_tail_ix(rob_tail),
    .o_full(rob_full), .o_q1_ready(q1_ready), .o_q2_ready(q2_ready),
    .o_q1_value(q1_value), .o_q2_value(q2_value), .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd), .o_commit_value(o_commit_value), .o_commit_ix(commit_ix)
  );

  alu_station alu_station_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_issue(issue), .i_func(alu_func),
    .i_rob_ix(rob_tail), .i_vi(op_a), .i_vj(op_b), .i_ready_i(rdy_a), .i_ready_j(rdy_b),
    .i_qi(rf_tag1), .i_qj(rf_tag2), .i_cdb_valid(cdb_valid), .i_cdb_rob_ix(cdb_rob_ix),
    .i_cdb_value(cdb_value), .o_full(rs_full), .o_disp_valid(disp_valid),
    .o_disp_func(disp_func), .o_disp_a(disp_a), .o_disp_b(disp_b),
    .o_disp_rob_ix(disp_rob_ix)
  );

  alu_unit alu_unit_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_valid(disp_valid), .i_func(disp_func),
    .i_a(disp_a), .i_b(disp_b), .i_rob_ix(disp_rob_ix), .o_cdb_valid(cdb_valid),
    .o_cdb_rob_ix(cdb_rob_ix), .o_cdb_value(cdb_value)
  );

endmodule

// ==== tests/ooo_core_tb.sv ====
`timescale 1ns/1ns

module ooo_core_tb;

  localparam int RST_CYCLES   = 10;
  localparam int CYC_PER_INST = 200;
  localparam int BURST_LEN    = 24;

  logic               clk_100mhz;
  logic               sys_rst;
  logic               i_inst_valid;
  ooo_pkg::instr_t    i_inst;
  logic               o_inst_ready;
  logic               o_commit_valid;
  ooo_pkg::reg_addr_t o_commit_rd;
  ooo_pkg::word_t     o_commit_value;

  ooo_pkg::word_t     arch [32];  // reference register file
  ooo_pkg::reg_addr_t exp_rd [$];
  ooo_pkg::word_t     exp_val [$];
  int                 n_sent;
  int                 n_commits;
  int                 n_stalls;     // cycles spent waiting on o_inst_ready
  logic [31:0]        rng;

  ooo_core ooo_core_i (
    .clk_100mhz(clk_100mhz), .sys_rst(sys_rst), .i_inst_valid(i_inst_valid),
    .i_inst(i_inst), .o_inst_ready(o_inst_ready), .o_commit_valid(o_commit_valid),
    .o_commit_rd(o_commit_rd), .o_commit_value(o_commit_value)
  );

  always #5 clk_100mhz = ~clk_100mhz;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic ooo_pkg::instr_t op_word(input logic [6:0] f7, input logic [4:0] rs2,
                                              input logic [4:0] rs1, input logic [2:0] f3,
                                              input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic ooo_pkg::instr_t opimm_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic ooo_pkg::instr_t lui_word(input logic [19:0] upper, input logic [4:0] rd);
    return {upper, rd, 7'b0110111};
  endfunction

  // rv32i alu semantics with alt as funct7 bit 5
  function automatic ooo_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                             input ooo_pkg::word_t a, input ooo_pkg::word_t b);
    case (f3)
      3'b000:  return alt ? a - b : a + b;
      3'b001:  return a << b[4:0];
      3'b010:  return {31'b0, $signed(a) < $signed(b)};
      3'b011:  return {31'b0, a < b};
      3'b100:  return a ^ b;
      3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'b110:  return a | b;
      default: return a & b;
    endcase
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_eq(input string what, input ooo_pkg::word_t got,
                          input ooo_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  // program order model run on every accepted instruction
  task automatic model_inst(input ooo_pkg::instr_t inst);
    logic [4:0]     rd;
    ooo_pkg::word_t a;
    ooo_pkg::word_t res;
    logic           supported;
    rd        = inst[11:7];
    a         = arch[inst[19:15]];
    res       = '0;
    supported = 1'b1;
    case (inst[6:0])
      7'b0110011: res = alu_ref(inst[14:12], inst[30], a, arch[inst[24:20]]);
      7'b0010011: begin
        // bit 30 selects srai only since there is no subtract immediate
        res = alu_ref(inst[14:12], inst[14:12] == 3'b101 && inst[30], a,
                      {{20{inst[31]}}, inst[31:20]});
      end
      7'b0110111: res = {inst[31:12], 12'b0};
      default:    supported = 1'b0;
    endcase
    if (supported) begin
      exp_rd.push_back(rd);
      exp_val.push_back(res);
      if (rd != 5'd0) arch[rd] = res;  // x0 stays zero
    end
  endtask

  // caller sits on a rising edge and gets back on the accepting edge
  task automatic send_inst(input ooo_pkg::instr_t inst);
    logic taken;
    taken        = 1'b0;
    i_inst_valid <= 1'b1;
    i_inst       <= inst;
    while (!taken) begin
      @(negedge clk_100mhz);
      taken = o_inst_ready;  // ready ignores valid and holds until the edge
      if (!taken) n_stalls++;
      @(posedge clk_100mhz);
    end
    model_inst(inst);
    n_sent++;
  endtask

  task automatic load_const(input logic [4:0] rd, input ooo_pkg::word_t value);
    ooo_pkg::word_t upper;
    upper = value + 32'h800;  // make up for the sign of the addi immediate
    send_inst(lui_word(upper[31:12], rd));
    send_inst(opimm_word(value[11:0], rd, 3'b000, rd));
  endtask

  task automatic drain;
    i_inst_valid <= 1'b0;
    while (exp_rd.size() != 0) @(posedge clk_100mhz);
    repeat (5) @(posedge clk_100mhz);  // room for a stray commit
  endtask

  task automatic check_commit;
    ooo_pkg::reg_addr_t rd;
    ooo_pkg::word_t     value;
    rd    = exp_rd.pop_front();
    value = exp_val.pop_front();
    check_eq("commit rd", 32'(o_commit_rd), 32'(rd));
    check_eq("commit value", o_commit_value, value);
    n_commits++;
  endtask

  always @(negedge clk_100mhz) begin
    if (!sys_rst && o_commit_valid) begin
      if (exp_rd.size() == 0) abort_run("a commit appeared with no instruction outstanding");
      else check_commit();
    end
  end

  task automatic imm_independent;
    send_inst(opimm_word(12'd100, 5'd0, 3'b000, 5'd1));  // addi x1, x0, 100
    send_inst(opimm_word(12'hfff, 5'd0, 3'b000, 5'd2));  // -1
    send_inst(lui_word(20'hdeadb, 5'd3));
    send_inst(opimm_word(12'h800, 5'd0, 3'b000, 5'd4));  // most negative imm
    send_inst(lui_word(20'h12345, 5'd5));
    send_inst(opimm_word(12'h7ff, 5'd0, 3'b000, 5'd6));
    drain();
  endtask

  task automatic dependency_chain;
    int k;
    send_inst(opimm_word(12'd7, 5'd0, 3'b000, 5'd7));
    for (k = 0; k < 6; k++) begin
      send_inst(opimm_word(12'd3, 5'd7, 3'b000, 5'd7));  // addi x7, x7, 3
    end
    send_inst(op_word(7'b0, 5'd7, 5'd7, 3'b000, 5'd8));         // add x8, x7, x7
    send_inst(op_word(7'b0100000, 5'd7, 5'd8, 3'b000, 5'd9));   // sub x9, x8, x7
    send_inst(opimm_word(12'd2, 5'd9, 3'b001, 5'd10));          // slli x10, x9, 2
    send_inst(op_word(7'b0, 5'd10, 5'd9, 3'b110, 5'd11));       // or x11, x9, x10
    send_inst(op_word(7'b0, 5'd11, 5'd8, 3'b100, 5'd8));        // xor x8, x8, x11
    drain();
  endtask

  task automatic alu_functions;
    ooo_pkg::word_t a;
    ooo_pkg::word_t b;
    logic [11:0]    imm;
    int             round;
    int             f;
    for (round = 0; round < 3; round++) begin
      rng = xorshift32(rng);
      a   = rng;
      rng = xorshift32(rng);
      b   = rng;
      b[7] = 1'b1;                     // shift amount above 31 before masking
      if (round == 0) a[31] = 1'b1;    // negative rs1
      if (round == 1) b[31] = 1'b1;
      load_const(5'd1, a);
      load_const(5'd2, b);
      for (f = 0; f < 8; f++) begin
        send_inst(op_word(7'b0, 5'd2, 5'd1, 3'(f), 5'(3 + f)));
      end
      send_inst(op_word(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd11));  // sub
      send_inst(op_word(7'b0100000, 5'd2, 5'd1, 3'b101, 5'd12));  // sra
      rng = xorshift32(rng);
      for (f = 0; f < 8; f++) begin
        imm = rng[11:0];
        if (f == 1 || f == 5) imm = {7'b0, rng[16:12]};
        send_inst(opimm_word(imm, 5'd1, 3'(f), 5'(13 + f)));
      end
      send_inst(opimm_word({7'b0100000, rng[20:16]}, 5'd1, 3'b101, 5'd21));  // srai
    end
    drain();
  endtask

  task automatic backpressure_burst;
    int k;
    int stalls_before;
    int commits_before;
    load_const(5'd10, 32'h0f0f_1234);
    load_const(5'd11, 32'hfedc_ba98);
    drain();
    stalls_before  = n_stalls;
    commits_before = n_commits;
    for (k = 0; k < BURST_LEN; k++) begin
      case (k % 4)
        0:       send_inst(op_word(7'b0, 5'd11, 5'd10, 3'b000, 5'd10));       // add
        1:       send_inst(opimm_word(12'(k * 37), 5'd10, 3'b100, 5'd11));     // xori
        2:       send_inst(op_word(7'b0100000, 5'd10, 5'd11, 3'b000, 5'd12)); // sub
        default: send_inst(op_word(7'b0100000, 5'd11, 5'd12, 3'b101, 5'd10)); // sra
      endcase
    end
    drain();
    check_eq("burst commit count", n_commits - commits_before, BURST_LEN);
    check_eq("burst saw back-pressure", (n_stalls > stalls_before) ? 32'd1 : 32'd0, 32'd1);
  endtask

  task automatic x0_and_unsupported;
    int commits_before;
    commits_before = n_commits;
    send_inst(opimm_word(12'h123, 5'd0, 3'b000, 5'd5));
    send_inst(opimm_word(12'd77, 5'd5, 3'b000, 5'd0));   // addi x0 still commits
    send_inst(op_word(7'b0, 5'd5, 5'd5, 3'b000, 5'd0));
    send_inst(lui_word(20'habcde, 5'd0));
    send_inst(op_word(7'b0, 5'd0, 5'd5, 3'b000, 5'd6));  // add x6, x5, x0
    send_inst(op_word(7'b0, 5'd0, 5'd0, 3'b110, 5'd8));  // or x8, x0, x0
    send_inst(32'h0000_2083);                             // lw x1 gets dropped
    send_inst(opimm_word(12'd1, 5'd0, 3'b000, 5'd9));
    send_inst(32'h0020_8463);                             // beq gets dropped
    send_inst(op_word(7'b0, 5'd0, 5'd1, 3'b000, 5'd11)); // x1 must be untouched
    send_inst(32'h0000_006f);                             // jal gets dropped
    drain();
    // eight of the eleven are alu instructions
    check_eq("x0 test commit count", n_commits - commits_before, 32'd8);
  endtask

  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= RST_CYCLES + CYC_PER_INST * (n_sent + 1)) begin
      @(posedge clk_100mhz);
      cycles++;
    end
    if (exp_rd.size() != 0) begin
      abort_run($sformatf("timeout: %0d expected commits never arrived", exp_rd.size()));
    end else begin
      abort_run("timeout: the DUT stopped accepting instructions");
    end
  end

  initial begin
    clk_100mhz   = 1'b0;
    sys_rst      = 1'b1;
    i_inst_valid = 1'b0;
    i_inst       = '0;
    n_sent       = 0;
    n_commits    = 0;
    n_stalls     = 0;
    rng          = 32'h17bd68d5;
    for (int r = 0; r < 32; r++) arch[r] = '0;
    repeat (RST_CYCLES) @(posedge clk_100mhz);
    sys_rst <= 1'b0;
    imm_independent();
    dependency_chain();
    alu_functions();
    backpressure_burst();
    x0_and_unsupported();
    if (exp_rd.size() != 0) begin
      abort_run("expected commits are still outstanding at the end of the run");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// ==== ooo_core.f ====
+incdir+design
design/ooo_pkg.sv
design/inst_decode.sv
design/rename_regfile.sv
design/alu_station.sv
design/alu_unit.sv
design/reorder_buffer.sv
design/ooo_core.sv
tests/ooo_core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -Wno-fatal --top-module ooo_core_tb -f ooo_core.f \
  -o ooo_core_sim > build.log 2>&1 || { echo "verilator build failed, see build.log"; exit 1; }
./obj_dir/ooo_core_sim > sim.log 2>&1
grep -q "Something failed" sim.log && { echo "simulation failed, see sim.log"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation ended without a result, see sim.log"; exit 1; }
echo "simulation passed"
exit 0
